/* list.f */
rtl/mips_pkg.sv
rtl/id_decoder.sv
rtl/regfile.sv
rtl/operand_forward.sv
rtl/id_ex_reg.sv
rtl/mips_id_top.sv
tb/tb_mips_id.sv

/* rtl/id_decoder.sv */
// instruction decoder, purely combinational
// register forms need shamt == 0, immediate shifts need rs == 0, else invalid
// MOVN/MOVZ write decision comes from the forwarded rt value on op2_i,
// so op2_i must be the resolved operand for the same instruction
// unknown codes give inst_valid and wreg low, aluop OP_NOP
`timescale 1ns/1ps

module id_decoder (
    input  mips_pkg::inst_t    inst_i,
    input  mips_pkg::data_t    op2_i,
    output mips_pkg::id_ctrl_t ctrl_o
);

    logic [5:0]          opcode;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          shamt;
    logic [5:0]          funct;

    mips_pkg::id_ctrl_t  dec;      // everything except the MOVN/MOVZ write gate
    logic                r_form;   // rs, rt -> rd
    logic                sh_form;  // shamt, rt -> rd
    logic                i_form;   // rs, imm -> rt
    logic                is_movn;
    logic                is_movz;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];

    always_comb begin
        dec           = '0;
        dec.aluop     = mips_pkg::OP_NOP;
        dec.alusel    = mips_pkg::SEL_NOP;
        dec.wd        = rd;
        dec.reg1_addr = rs;
        dec.reg2_addr = rt;
        r_form        = 1'b0;
        sh_form       = 1'b0;
        i_form        = 1'b0;
        is_movn       = 1'b0;
        is_movz       = 1'b0;

        case (opcode)
            mips_pkg::OPC_SPECIAL: begin
                case (funct)
                    mips_pkg::FN_AND: begin
                        dec.aluop  = mips_pkg::OP_AND;
                        dec.alusel = mips_pkg::SEL_LOGIC;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_OR: begin
                        dec.aluop  = mips_pkg::OP_OR;
                        dec.alusel = mips_pkg::SEL_LOGIC;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_XOR: begin
                        dec.aluop  = mips_pkg::OP_XOR;
                        dec.alusel = mips_pkg::SEL_LOGIC;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_NOR: begin
                        dec.aluop  = mips_pkg::OP_NOR;
                        dec.alusel = mips_pkg::SEL_LOGIC;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_SLLV, mips_pkg::FN_SLL: begin
                        dec.aluop  = mips_pkg::OP_SLL;
                        dec.alusel = mips_pkg::SEL_SHIFT;
                        r_form     = (funct == mips_pkg::FN_SLLV);
                        sh_form    = (funct == mips_pkg::FN_SLL);
                    end
                    mips_pkg::FN_SRLV, mips_pkg::FN_SRL: begin
                        dec.aluop  = mips_pkg::OP_SRL;
                        dec.alusel = mips_pkg::SEL_SHIFT;
                        r_form     = (funct == mips_pkg::FN_SRLV);
                        sh_form    = (funct == mips_pkg::FN_SRL);
                    end
                    mips_pkg::FN_SRAV, mips_pkg::FN_SRA: begin
                        dec.aluop  = mips_pkg::OP_SRA;
                        dec.alusel = mips_pkg::SEL_SHIFT;
                        r_form     = (funct == mips_pkg::FN_SRAV);
                        sh_form    = (funct == mips_pkg::FN_SRA);
                    end
                    mips_pkg::FN_MOVN: begin
                        dec.aluop  = mips_pkg::OP_MOVN;
                        dec.alusel = mips_pkg::SEL_MOVE;
                        r_form     = 1'b1;
                        is_movn    = 1'b1;
                    end
                    mips_pkg::FN_MOVZ: begin
                        dec.aluop  = mips_pkg::OP_MOVZ;
                        dec.alusel = mips_pkg::SEL_MOVE;
                        r_form     = 1'b1;
                        is_movz    = 1'b1;
                    end
                    mips_pkg::FN_SLT: begin
                        dec.aluop  = mips_pkg::OP_SLT;
                        dec.alusel = mips_pkg::SEL_ARITH;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_SLTU: begin
                        dec.aluop  = mips_pkg::OP_SLTU;
                        dec.alusel = mips_pkg::SEL_ARITH;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_ADD: begin
                        dec.aluop  = mips_pkg::OP_ADD;
                        dec.alusel = mips_pkg::SEL_ARITH;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_ADDU: begin
                        dec.aluop  = mips_pkg::OP_ADDU;
                        dec.alusel = mips_pkg::SEL_ARITH;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_SUB: begin
                        dec.aluop  = mips_pkg::OP_SUB;
                        dec.alusel = mips_pkg::SEL_ARITH;
                        r_form     = 1'b1;
                    end
                    mips_pkg::FN_SUBU: begin
                        dec.aluop  = mips_pkg::OP_SUBU;
                        dec.alusel = mips_pkg::SEL_ARITH;
                        r_form     = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            mips_pkg::OPC_ANDI, mips_pkg::OPC_ORI, mips_pkg::OPC_XORI: begin
                dec.alusel = mips_pkg::SEL_LOGIC;
                dec.imm    = {16'h0, inst_i[15:0]};
                i_form     = 1'b1;
                case (opcode)
                    mips_pkg::OPC_ANDI: dec.aluop = mips_pkg::OP_AND;
                    mips_pkg::OPC_ORI:  dec.aluop = mips_pkg::OP_OR;
                    default:            dec.aluop = mips_pkg::OP_XOR;
                endcase
            end
            mips_pkg::OPC_LUI: begin
                dec.aluop  = mips_pkg::OP_OR;      // rs | (imm << 16), rs is $0
                dec.alusel = mips_pkg::SEL_LOGIC;
                dec.imm    = {inst_i[15:0], 16'h0};
                i_form     = 1'b1;
            end
            mips_pkg::OPC_ADDI, mips_pkg::OPC_ADDIU,
            mips_pkg::OPC_SLTI, mips_pkg::OPC_SLTIU: begin
                dec.alusel = mips_pkg::SEL_ARITH;
                dec.imm    = {{16{inst_i[15]}}, inst_i[15:0]};
                i_form     = 1'b1;
                case (opcode)
                    mips_pkg::OPC_ADDI:  dec.aluop = mips_pkg::OP_ADDI;
                    mips_pkg::OPC_ADDIU: dec.aluop = mips_pkg::OP_ADDIU;
                    mips_pkg::OPC_SLTI:  dec.aluop = mips_pkg::OP_SLT;
                    default:             dec.aluop = mips_pkg::OP_SLTU;
                endcase
            end
            default: begin
            end
        endcase

        if (i_form) begin
            dec.reg1_read  = 1'b1;
            dec.wd         = rt;
            dec.wreg       = 1'b1;
            dec.inst_valid = 1'b1;
        end else if (sh_form && rs == mips_pkg::REG_ZERO) begin
            dec.reg2_read  = 1'b1;            // op1 falls back to the shift amount
            dec.imm        = {27'h0, shamt};
            dec.wreg       = 1'b1;
            dec.inst_valid = 1'b1;
        end else if (r_form && shamt == 5'd0) begin
            dec.reg1_read  = 1'b1;
            dec.reg2_read  = 1'b1;
            dec.wreg       = 1'b1;
            dec.inst_valid = 1'b1;
        end else begin
            dec.aluop  = mips_pkg::OP_NOP;    // malformed or unknown
            dec.alusel = mips_pkg::SEL_NOP;
            dec.imm    = '0;
        end
    end

    // conditional moves gate the write on the resolved rt value
    always_comb begin
        ctrl_o = dec;
        if (is_movn) begin
            ctrl_o.wreg = dec.wreg && (op2_i != '0);
        end else if (is_movz) begin
            ctrl_o.wreg = dec.wreg && (op2_i == '0);
        end
    end

    always_comb begin
        assert (ctrl_o.inst_valid || !ctrl_o.wreg)
            else $error("decoder: write enabled for invalid instruction");
    end

endmodule

/* rtl/id_ex_reg.sv */
// decode/execute pipeline register, loads every cycle, no stall
// reset loads a bubble: no write, invalid, OP_NOP, zero operands
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mips_pkg::id_ctrl_t   ctrl_i,
    input  mips_pkg::data_t      op1_i,
    input  mips_pkg::data_t      op2_i,
    output mips_pkg::ex_bundle_t ex_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_o            <= '0;
            ex_o.aluop      <= mips_pkg::OP_NOP;
            ex_o.alusel     <= mips_pkg::SEL_NOP;
        end else begin
            ex_o.aluop      <= ctrl_i.aluop;
            ex_o.alusel     <= ctrl_i.alusel;
            ex_o.wd         <= ctrl_i.wd;
            ex_o.wreg       <= ctrl_i.wreg;
            ex_o.inst_valid <= ctrl_i.inst_valid;
            ex_o.reg1       <= op1_i;
            ex_o.reg2       <= op2_i;
        end
    end

    // no stray write may leave the stage right after reset
    a_bubble_after_reset: assert property (@(posedge clk)
        rst_i |=> (!ex_o.wreg && !ex_o.inst_valid))
        else $error("id_ex_reg: write enable set after reset");

endmodule

/* rtl/mips_id_top.sv */
// decode stage top: decoder, register file, forwarding and ID/EX register
// one instruction per cycle, no stall or back-pressure
// ex_fwd_i and mem_fwd_i carry results not yet in the register file
// wb_i is the write-back port into the register file
`timescale 1ns/1ps

module mips_id_top (
    input  logic                 clk,
    input  logic                 rst_i,
    input  mips_pkg::inst_t      inst_i,
    input  mips_pkg::wb_port_t   wb_i,
    input  mips_pkg::wb_port_t   ex_fwd_i,
    input  mips_pkg::wb_port_t   mem_fwd_i,
    output mips_pkg::ex_bundle_t ex_o
);

    mips_pkg::id_ctrl_t ctrl;
    mips_pkg::data_t    rdata1;
    mips_pkg::data_t    rdata2;
    mips_pkg::data_t    op1;
    mips_pkg::data_t    op2;

    id_decoder u_decoder (
        .inst_i (inst_i),
        .op2_i  (op2),
        .ctrl_o (ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_i     (wb_i),
        .raddr1_i (ctrl.reg1_addr),
        .raddr2_i (ctrl.reg2_addr),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_forward u_fwd1 (
        .read_i    (ctrl.reg1_read),
        .addr_i    (ctrl.reg1_addr),
        .rf_data_i (rdata1),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op1)
    );

    operand_forward u_fwd2 (
        .read_i    (ctrl.reg2_read),
        .addr_i    (ctrl.reg2_addr),
        .rf_data_i (rdata2),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op2)
    );

    id_ex_reg u_id_ex (
        .clk    (clk),
        .rst_i  (rst_i),
        .ctrl_i (ctrl),
        .op1_i  (op1),
        .op2_i  (op2),
        .ex_o   (ex_o)
    );

endmodule

/* rtl/mips_pkg.sv */
// shared types and codes for the MIPS-style decode stage
// only the logic, shift, arithmetic and conditional move groups are encoded
// multiply/divide, HI/LO, CLZ/CLO, SYNC and PREF opcodes decode as invalid
// aluop and alusel values must agree with the execute stage that consumes them
package mips_pkg;

    typedef logic [31:0] data_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [2:0]  alusel_t;

    localparam reg_addr_t REG_ZERO = 5'd0;

    // primary opcodes, inst[31:26]
    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_SLTIU   = 6'b001011;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;

    // SPECIAL function codes, inst[5:0]
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_MOVZ = 6'b001010;
    localparam logic [5:0] FN_MOVN = 6'b001011;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // ALU operations
    localparam aluop_t OP_NOP   = 8'b00000000;
    localparam aluop_t OP_AND   = 8'b00100100;
    localparam aluop_t OP_OR    = 8'b00100101;
    localparam aluop_t OP_XOR   = 8'b00100110;
    localparam aluop_t OP_NOR   = 8'b00100111;
    localparam aluop_t OP_SLL   = 8'b01111100;
    localparam aluop_t OP_SRL   = 8'b00000010;
    localparam aluop_t OP_SRA   = 8'b00000011;
    localparam aluop_t OP_MOVZ  = 8'b00001010;
    localparam aluop_t OP_MOVN  = 8'b00001011;
    localparam aluop_t OP_SLT   = 8'b00101010;
    localparam aluop_t OP_SLTU  = 8'b00101011;
    localparam aluop_t OP_ADD   = 8'b00100000;
    localparam aluop_t OP_ADDU  = 8'b00100001;
    localparam aluop_t OP_SUB   = 8'b00100010;
    localparam aluop_t OP_SUBU  = 8'b00100011;
    localparam aluop_t OP_ADDI  = 8'b01010101;
    localparam aluop_t OP_ADDIU = 8'b01010110;

    // result classes
    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_MOVE  = 3'b011;
    localparam alusel_t SEL_ARITH = 3'b100;

    // pending register write, used for forwards and the write port
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        data_t     data;
    } wb_port_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        data_t     imm;
        logic      inst_valid;
    } id_ctrl_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        reg_addr_t wd;
        logic      wreg;
        logic      inst_valid;
        data_t     reg1;
        data_t     reg2;
    } ex_bundle_t;

endpackage

/* rtl/operand_forward.sv */
// operand select for one decode read port
// priority: immediate when not read, then execute, then memory, then regfile
// a forward targeting $0 is never taken
`timescale 1ns/1ps

module operand_forward (
    input  logic                read_i,
    input  mips_pkg::reg_addr_t addr_i,
    input  mips_pkg::data_t     rf_data_i,
    input  mips_pkg::data_t     imm_i,
    input  mips_pkg::wb_port_t  ex_fwd_i,
    input  mips_pkg::wb_port_t  mem_fwd_i,
    output mips_pkg::data_t     operand_o
);

    logic nonzero;
    logic ex_hit;
    logic mem_hit;

    assign nonzero = (addr_i != mips_pkg::REG_ZERO);
    assign ex_hit  = nonzero && ex_fwd_i.we && (ex_fwd_i.addr == addr_i);
    assign mem_hit = nonzero && mem_fwd_i.we && (mem_fwd_i.addr == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.data;   // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.data;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

/* rtl/regfile.sv */
// 32 x 32 register file, two async reads and one write per cycle
// register zero is hardwired, writes to it are dropped
// a read of the address being written this cycle returns the write data
// all registers clear on reset
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                rst_i,
    input  mips_pkg::wb_port_t  wb_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::data_t     rdata1_o,
    output mips_pkg::data_t     rdata2_o
);

    mips_pkg::data_t regs [1:31];

    function automatic mips_pkg::data_t read_port(input mips_pkg::reg_addr_t addr);
        mips_pkg::data_t val;
        if (addr == mips_pkg::REG_ZERO) begin
            val = '0;
        end else if (wb_i.we && wb_i.addr == addr) begin
            val = wb_i.data;   // write-through
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != mips_pkg::REG_ZERO) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    always_comb rdata1_o = read_port(raddr1_i);
    always_comb rdata2_o = read_port(raddr2_i);

    // holds even while $0 is the target of a pending write
    a_zero_reads_zero: assert property (@(posedge clk) disable iff (rst_i)
        ((raddr1_i != mips_pkg::REG_ZERO) || (rdata1_o == '0)) &&
        ((raddr2_i != mips_pkg::REG_ZERO) || (rdata2_o == '0)))
        else $error("regfile: register zero read back nonzero");

endmodule

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_mips_id -f list.f
./obj_dir/Vtb_mips_id | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb/tb_mips_id.sv */
// directed testbench for the decode stage, checking done by concurrent assertions
// expected bundles come from the instruction fields, a shadow register array
// and the forward ports driven together with each instruction
// only well-formed encodings: shamt 0 on register forms, rs 0 on immediate shifts
// ex_o is compared two edges after an instruction is driven
`timescale 1ns/1ps

module tb_mips_id;

    localparam int RESET_CYCLES = 16;
    localparam int ROUNDS       = 4;
    // reset 21, reg 87, imm 35, shift 15, forward 10, move 14, rounded up
    localparam int TEST_CYCLES  = 200;
    localparam int MAX_CYCLES   = 2 * TEST_CYCLES;
    localparam mips_pkg::inst_t IDLE_INST = 32'hFC00_0000;  // opcode 111111, unknown

    typedef struct packed {
        logic                 chk;   // compare on this cycle
        logic                 full;  // all fields, else valid/wreg/aluop only
        mips_pkg::ex_bundle_t b;
    } expect_t;

    logic                 clk;
    logic                 rst_i;
    mips_pkg::inst_t      inst_i;
    mips_pkg::wb_port_t   wb_i;
    mips_pkg::wb_port_t   ex_fwd_i;
    mips_pkg::wb_port_t   mem_fwd_i;
    mips_pkg::ex_bundle_t ex_o;

    mips_pkg::data_t    shadow [0:31];
    mips_pkg::wb_port_t nxt_wb  = '0;
    mips_pkg::wb_port_t nxt_ex  = '0;
    mips_pkg::wb_port_t nxt_mem = '0;
    expect_t            exp_d   = '0;
    expect_t            exp_q   = '0;
    int                 seed    = 9954;
    int                 errors  = 0;
    int                 checks  = 0;
    int                 tests_run    = 0;
    int                 tests_failed = 0;
    int                 cycles  = 0;

    mips_id_top DUT (
        .clk       (clk),
        .rst_i     (rst_i),
        .inst_i    (inst_i),
        .wb_i      (wb_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .ex_o      (ex_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    always @(posedge clk) begin
        exp_q <= exp_d;   // lines up with the ID/EX register
    end

    function automatic void report_mismatch(input string what);
        errors++;
        $display("Mismatch at %0t: %s", $time, what);
    endfunction

    a_reset_bubble: assert property (@(posedge clk)
        rst_i |=> (!ex_o.wreg && !ex_o.inst_valid && ex_o.aluop == mips_pkg::OP_NOP))
        else report_mismatch("ex_o is not a bubble after a reset edge");

    a_control: assert property (@(posedge clk)
        exp_q.chk |-> (ex_o.inst_valid == exp_q.b.inst_valid && ex_o.wreg == exp_q.b.wreg
                       && ex_o.aluop == exp_q.b.aluop))
        else report_mismatch($sformatf("valid %b wreg %b aluop %h, expected %b %b %h",
            $sampled(ex_o.inst_valid), $sampled(ex_o.wreg), $sampled(ex_o.aluop),
            $sampled(exp_q.b.inst_valid), $sampled(exp_q.b.wreg), $sampled(exp_q.b.aluop)));

    a_class_dest: assert property (@(posedge clk)
        exp_q.chk && exp_q.full |-> (ex_o.alusel == exp_q.b.alusel && ex_o.wd == exp_q.b.wd))
        else report_mismatch($sformatf("alusel %h wd %0d, expected %h %0d",
            $sampled(ex_o.alusel), $sampled(ex_o.wd),
            $sampled(exp_q.b.alusel), $sampled(exp_q.b.wd)));

    a_op1: assert property (@(posedge clk)
        exp_q.chk && exp_q.full |-> ex_o.reg1 == exp_q.b.reg1)
        else report_mismatch($sformatf("reg1 %h, expected %h",
            $sampled(ex_o.reg1), $sampled(exp_q.b.reg1)));

    a_op2: assert property (@(posedge clk)
        exp_q.chk && exp_q.full |-> ex_o.reg2 == exp_q.b.reg2)
        else report_mismatch($sformatf("reg2 %h, expected %h",
            $sampled(ex_o.reg2), $sampled(exp_q.b.reg2)));

    function automatic mips_pkg::data_t rand_word();
        return $random(seed);
    endfunction

    function automatic mips_pkg::wb_port_t make_port(input logic we,
            input mips_pkg::reg_addr_t addr, input mips_pkg::data_t data);
        return {we, addr, data};
    endfunction

    function automatic mips_pkg::inst_t r_type(input logic [5:0] funct,
            input mips_pkg::reg_addr_t rs, rt, rd);
        return {6'b000000, rs, rt, rd, 5'b00000, funct};
    endfunction

    // value the decode stage should see: forwards first, then write-through
    function automatic mips_pkg::data_t operand_value(input mips_pkg::reg_addr_t addr);
        mips_pkg::data_t val;
        if (addr == mips_pkg::REG_ZERO) begin
            val = '0;
        end else if (nxt_ex.we && nxt_ex.addr == addr) begin
            val = nxt_ex.data;
        end else if (nxt_mem.we && nxt_mem.addr == addr) begin
            val = nxt_mem.data;
        end else if (nxt_wb.we && nxt_wb.addr == addr) begin
            val = nxt_wb.data;
        end else begin
            val = shadow[addr];
        end
        return val;
    endfunction

    function automatic expect_t make_expect(
        input mips_pkg::aluop_t    aluop,
        input mips_pkg::alusel_t   alusel,
        input mips_pkg::reg_addr_t wd,
        input logic                wreg,
        input mips_pkg::data_t     reg1,
        input mips_pkg::data_t     reg2
    );
        expect_t e;
        e.chk          = 1'b1;
        e.full         = 1'b1;
        e.b.aluop      = aluop;
        e.b.alusel     = alusel;
        e.b.wd         = wd;
        e.b.wreg       = wreg;
        e.b.inst_valid = 1'b1;
        e.b.reg1       = reg1;
        e.b.reg2       = reg2;
        return e;
    endfunction

    function automatic expect_t invalid_expect();
        expect_t e;
        e          = '0;
        e.chk      = 1'b1;
        e.b.aluop  = mips_pkg::OP_NOP;
        return e;
    endfunction

    task automatic drive_cycle(input mips_pkg::inst_t inst, input expect_t e);
        @(posedge clk);
        inst_i    <= inst;
        wb_i      <= nxt_wb;
        ex_fwd_i  <= nxt_ex;
        mem_fwd_i <= nxt_mem;
        exp_d     <= e;
        if (e.chk) begin
            checks++;
        end
        if (nxt_wb.we && nxt_wb.addr != mips_pkg::REG_ZERO) begin
            shadow[nxt_wb.addr] = nxt_wb.data;
        end
        nxt_wb  = '0;
        nxt_ex  = '0;
        nxt_mem = '0;
    endtask

    task automatic write_reg(input mips_pkg::reg_addr_t addr, input mips_pkg::data_t data);
        nxt_wb = make_port(1'b1, addr, data);
        drive_cycle(IDLE_INST, invalid_expect());
    endtask

    task automatic issue_reg(input logic [5:0] funct, input mips_pkg::aluop_t aluop,
            input mips_pkg::alusel_t alusel, input mips_pkg::reg_addr_t rd, rs, rt);
        drive_cycle(r_type(funct, rs, rt, rd),
            make_expect(aluop, alusel, rd, 1'b1, operand_value(rs), operand_value(rt)));
    endtask

    task automatic issue_imm(input logic [5:0] opc, input mips_pkg::aluop_t aluop,
            input mips_pkg::alusel_t alusel, input mips_pkg::reg_addr_t rs, rt,
            input logic [15:0] imm, input mips_pkg::data_t imm_ext);
        drive_cycle({opc, rs, rt, imm},
            make_expect(aluop, alusel, rt, 1'b1, operand_value(rs), imm_ext));
    endtask

    task automatic issue_shift(input logic [5:0] funct, input mips_pkg::aluop_t aluop,
            input mips_pkg::reg_addr_t rd, rt, input logic [4:0] sa);
        drive_cycle({6'b000000, 5'd0, rt, rd, sa, funct},
            make_expect(aluop, mips_pkg::SEL_SHIFT, rd, 1'b1, {27'd0, sa}, operand_value(rt)));
    endtask

    task automatic issue_move(input logic if_nonzero, input mips_pkg::reg_addr_t rd, rs, rt);
        mips_pkg::data_t v2;
        logic            wreg;
        v2   = operand_value(rt);
        wreg = if_nonzero ? (v2 != '0) : (v2 == '0);
        drive_cycle(r_type(if_nonzero ? mips_pkg::FN_MOVN : mips_pkg::FN_MOVZ, rs, rt, rd),
            make_expect(if_nonzero ? mips_pkg::OP_MOVN : mips_pkg::OP_MOVZ,
                        mips_pkg::SEL_MOVE, rd, wreg, operand_value(rs), v2));
    endtask

    // drain until the last check has run, then report the test
    task automatic close_test(input string name, input int errors_before);
        drive_cycle(IDLE_INST, '0);
        drive_cycle(IDLE_INST, '0);
        @(posedge clk);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d mismatches", name, errors - errors_before);
        end
    endtask

    initial begin
        int              e0;
        mips_pkg::data_t word;
        logic [15:0]     imm_hi;
        logic [15:0]     imm_lo;
        rst_i     <= 1'b1;
        inst_i    <= IDLE_INST;
        wb_i      <= '0;
        ex_fwd_i  <= '0;
        mem_fwd_i <= '0;
        shadow    = '{default: '0};
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;

        e0 = errors;
        drive_cycle(IDLE_INST, invalid_expect());
        drive_cycle(IDLE_INST, invalid_expect());
        close_test("reset", e0);

        e0 = errors;
        for (int r = 0; r < ROUNDS; r++) begin
            for (int k = 1; k <= 8; k++) begin
                write_reg(mips_pkg::reg_addr_t'(k), rand_word());
            end
            issue_reg(mips_pkg::FN_AND,  mips_pkg::OP_AND,  mips_pkg::SEL_LOGIC, 5'd9,  5'd1, 5'd2);
            issue_reg(mips_pkg::FN_OR,   mips_pkg::OP_OR,   mips_pkg::SEL_LOGIC, 5'd10, 5'd3, 5'd4);
            issue_reg(mips_pkg::FN_XOR,  mips_pkg::OP_XOR,  mips_pkg::SEL_LOGIC, 5'd11, 5'd5, 5'd6);
            issue_reg(mips_pkg::FN_NOR,  mips_pkg::OP_NOR,  mips_pkg::SEL_LOGIC, 5'd12, 5'd7, 5'd8);
            issue_reg(mips_pkg::FN_ADD,  mips_pkg::OP_ADD,  mips_pkg::SEL_ARITH, 5'd13, 5'd2, 5'd1);
            issue_reg(mips_pkg::FN_ADDU, mips_pkg::OP_ADDU, mips_pkg::SEL_ARITH, 5'd14, 5'd4, 5'd3);
            issue_reg(mips_pkg::FN_SUB,  mips_pkg::OP_SUB,  mips_pkg::SEL_ARITH, 5'd15, 5'd6, 5'd5);
            issue_reg(mips_pkg::FN_SUBU, mips_pkg::OP_SUBU, mips_pkg::SEL_ARITH, 5'd16, 5'd8, 5'd7);
            issue_reg(mips_pkg::FN_SLT,  mips_pkg::OP_SLT,  mips_pkg::SEL_ARITH, 5'd17, 5'd1, 5'd8);
            issue_reg(mips_pkg::FN_SLTU, mips_pkg::OP_SLTU, mips_pkg::SEL_ARITH, 5'd18, 5'd3, 5'd6);
            issue_reg(mips_pkg::FN_SLLV, mips_pkg::OP_SLL,  mips_pkg::SEL_SHIFT, 5'd19, 5'd5, 5'd2);
            issue_reg(mips_pkg::FN_SRLV, mips_pkg::OP_SRL,  mips_pkg::SEL_SHIFT, 5'd20, 5'd7, 5'd4);
            issue_reg(mips_pkg::FN_SRAV, mips_pkg::OP_SRA,  mips_pkg::SEL_SHIFT, 5'd21, 5'd6, 5'd1);
        end
        close_test("register forms", e0);

        e0 = errors;
        for (int r = 0; r < ROUNDS; r++) begin
            word   = rand_word();
            imm_hi = word[15:0] | 16'h8000;   // sign bit set
            imm_lo = word[31:16] & 16'h7FFF;
            issue_imm(mips_pkg::OPC_ANDI, mips_pkg::OP_AND, mips_pkg::SEL_LOGIC,
                      5'd1, 5'd22, imm_hi, {16'h0000, imm_hi});
            issue_imm(mips_pkg::OPC_ORI, mips_pkg::OP_OR, mips_pkg::SEL_LOGIC,
                      5'd2, 5'd23, imm_hi, {16'h0000, imm_hi});
            issue_imm(mips_pkg::OPC_XORI, mips_pkg::OP_XOR, mips_pkg::SEL_LOGIC,
                      5'd3, 5'd24, imm_hi, {16'h0000, imm_hi});
            issue_imm(mips_pkg::OPC_ADDI, mips_pkg::OP_ADDI, mips_pkg::SEL_ARITH,
                      5'd4, 5'd25, imm_hi, {16'hFFFF, imm_hi});
            issue_imm(mips_pkg::OPC_ADDIU, mips_pkg::OP_ADDIU, mips_pkg::SEL_ARITH,
                      5'd5, 5'd26, imm_hi, {16'hFFFF, imm_hi});
            issue_imm(mips_pkg::OPC_SLTI, mips_pkg::OP_SLT, mips_pkg::SEL_ARITH,
                      5'd6, 5'd27, imm_hi, {16'hFFFF, imm_hi});
            issue_imm(mips_pkg::OPC_SLTIU, mips_pkg::OP_SLTU, mips_pkg::SEL_ARITH,
                      5'd7, 5'd28, imm_hi, {16'hFFFF, imm_hi});
            issue_imm(mips_pkg::OPC_LUI, mips_pkg::OP_OR, mips_pkg::SEL_LOGIC,
                      5'd0, 5'd29, imm_lo, {imm_lo, 16'h0000});
        end
        close_test("immediate forms", e0);

        e0 = errors;
        for (int r = 0; r < ROUNDS; r++) begin
            word = rand_word();
            issue_shift(mips_pkg::FN_SLL, mips_pkg::OP_SLL, 5'd9,  5'd1, word[4:0]);
            issue_shift(mips_pkg::FN_SRL, mips_pkg::OP_SRL, 5'd10, 5'd2, word[9:5]);
            issue_shift(mips_pkg::FN_SRA, mips_pkg::OP_SRA, 5'd11, 5'd3, word[14:10]);
        end
        close_test("immediate shifts", e0);

        e0 = errors;
        nxt_ex  = make_port(1'b1, 5'd3, rand_word());   // both hit rs, execute wins
        nxt_mem = make_port(1'b1, 5'd3, rand_word());
        issue_reg(mips_pkg::FN_ADD, mips_pkg::OP_ADD, mips_pkg::SEL_ARITH, 5'd20, 5'd3, 5'd4);
        nxt_ex  = make_port(1'b1, 5'd4, rand_word());
        nxt_mem = make_port(1'b1, 5'd3, rand_word());
        issue_reg(mips_pkg::FN_ADD, mips_pkg::OP_ADD, mips_pkg::SEL_ARITH, 5'd20, 5'd3, 5'd4);
        nxt_ex  = make_port(1'b1, 5'd7, rand_word());
        nxt_mem = make_port(1'b0, 5'd3, rand_word());   // no write enable, no hit
        issue_reg(mips_pkg::FN_ADD, mips_pkg::OP_ADD, mips_pkg::SEL_ARITH, 5'd20, 5'd3, 5'd4);
        nxt_ex  = make_port(1'b1, 5'd0, rand_word());
        nxt_mem = make_port(1'b1, 5'd0, rand_word());
        nxt_wb  = make_port(1'b1, 5'd0, rand_word());
        issue_reg(mips_pkg::FN_OR, mips_pkg::OP_OR, mips_pkg::SEL_LOGIC, 5'd20, 5'd0, 5'd0);
        nxt_wb  = make_port(1'b1, 5'd5, rand_word());   // write-through
        issue_reg(mips_pkg::FN_SUB, mips_pkg::OP_SUB, mips_pkg::SEL_ARITH, 5'd20, 5'd5, 5'd6);
        issue_reg(mips_pkg::FN_SUB, mips_pkg::OP_SUB, mips_pkg::SEL_ARITH, 5'd20, 5'd5, 5'd6);
        nxt_wb  = make_port(1'b1, 5'd6, rand_word());
        nxt_mem = make_port(1'b1, 5'd6, rand_word());
        issue_reg(mips_pkg::FN_SUB, mips_pkg::OP_SUB, mips_pkg::SEL_ARITH, 5'd20, 5'd5, 5'd6);
        close_test("forwarding", e0);

        e0 = errors;
        write_reg(5'd8, '0);
        write_reg(5'd9, rand_word() | 32'h1);
        issue_move(1'b1, 5'd20, 5'd1, 5'd9);
        issue_move(1'b1, 5'd20, 5'd1, 5'd8);
        issue_move(1'b0, 5'd20, 5'd1, 5'd8);
        issue_move(1'b0, 5'd20, 5'd1, 5'd9);
        nxt_ex = make_port(1'b1, 5'd9, '0);   // forwarded zero decides
        issue_move(1'b1, 5'd20, 5'd1, 5'd9);
        issue_move(1'b0, 5'd20, 5'd1, 5'd0);
        drive_cycle({6'b011100, 5'd1, 5'd2, 5'd3, 5'd0, 6'b000010}, invalid_expect());
        drive_cycle({6'b100011, 5'd1, 5'd2, 16'h0010}, invalid_expect());
        drive_cycle(r_type(6'b011000, 5'd1, 5'd2, 5'd0), invalid_expect());
        close_test("moves and unknown codes", e0);

        $display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d cycles",
                 tests_run, tests_failed, checks, errors, cycles);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
